// File: tb.f
+incdir+verification
rtl/booth_pkg.sv
rtl/booth_apb_regs.sv
rtl/booth_ctrl.sv
rtl/booth_datapath.sv
rtl/booth_counter.sv
rtl/booth_mult_top.sv
verification/booth_tb.sv

// File: run.sh
#!/bin/sh
# build and run the Booth multiplier testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -j 0 \
    --top-module booth_tb -f tb.f -o booth_sim || exit 1

out=$(./obj_dir/booth_sim 2>&1)
echo "$out"

echo "$out" | grep -q "Test completed successfully" && exit 0 || exit 1

// File: verification/booth_apb_tasks.svh
`ifndef BOOTH_APB_TASKS_SVH
`define BOOTH_APB_TASKS_SVH

// all bus tasks start and end right after a falling edge

function automatic logic [31:0] to_word(input logic [WIDTH-1:0] v);
    return 32'(v);   // zero extended, as the regs read back
endfunction

task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                         output logic err);
    req.paddr   = addr;
    req.pwrite  = 1'b1;
    req.pwdata  = data;
    req.psel    = 1'b1;
    req.penable = 1'b0;
    @(negedge clk);
    req.penable = 1'b1;
    @(posedge clk);
    err = rsp.pslverr;
    @(negedge clk);
    req.psel    = 1'b0;
    req.penable = 1'b0;
endtask

task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
                        output logic err);
    req.paddr   = addr;
    req.pwrite  = 1'b0;
    req.psel    = 1'b1;
    req.penable = 1'b0;
    @(negedge clk);
    req.penable = 1'b1;
    @(posedge clk);
    data = rsp.prdata;
    err  = rsp.pslverr;
    @(negedge clk);
    req.psel    = 1'b0;
    req.penable = 1'b0;
endtask

task automatic start_multiply(input logic signed [WIDTH-1:0] a,
                              input logic signed [WIDTH-1:0] b);
    logic [31:0] status;
    logic        err;

    write_reg(ADDR_MCAND, to_word(a), err);
    expect_equal("pslverr", 32'd0, 32'(err));
    write_reg(ADDR_MPLIER, to_word(b), err);
    expect_equal("pslverr", 32'd0, 32'(err));
    write_reg(ADDR_CTRL, 32'h1, err);
    expect_equal("pslverr", 32'd0, 32'(err));
    read_reg(ADDR_STATUS, status, err);
    expect_equal("STATUS", 32'h1, status);   // busy set, old done cleared
endtask

task automatic wait_for_done;
    logic [31:0] status;
    logic        err;
    int          polls;

    polls  = 0;
    status = '0;
    while (!status[1]) begin
        if (polls == MAX_POLLS) begin
            $display("done bit never set after %0d STATUS reads", MAX_POLLS);
            fail_run();
        end
        read_reg(ADDR_STATUS, status, err);
        polls++;
    end
    expect_equal("STATUS", 32'h2, status);
endtask

task automatic check_result(input logic signed [WIDTH-1:0] a,
                            input logic signed [WIDTH-1:0] b);
    logic [31:0] data;
    logic        err;
    int          expected;

    expected = int'(a) * int'(b);
    read_reg(ADDR_RESULT, data, err);
    expect_equal("pslverr", 32'd0, 32'(err));
    expect_equal("RESULT", expected, data);
endtask

task automatic run_multiply(input logic signed [WIDTH-1:0] a,
                            input logic signed [WIDTH-1:0] b);
    start_multiply(a, b);
    wait_for_done();
    check_result(a, b);
endtask

`endif

// File: verification/booth_tb.sv
module booth_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import booth_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int NUM_RANDOM  = 30;
    localparam int NUM_MULTS   = 6 + NUM_RANDOM + 1;   // directed, random, busy run
    localparam int WATCHDOG_CYCLES = NUM_MULTS * (WIDTH + 10) + 200;
    localparam int MAX_POLLS   = 2 * WIDTH;
    localparam logic [ADDR_W-1:0] ADDR_UNMAPPED = 8'h20;

    logic     clk;
    logic     rst;
    apb_req_t req;
    apb_rsp_t rsp;
    integer   seed;

    booth_mult_top u_booth_mult_top (
        .clk (clk),
        .rst (rst),
        .req (req),
        .rsp (rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run;
        $display("Test failed");
        $fatal;
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAIL time=%0t signal=%s expected=%h actual=%h", $time, sig, exp, act);
        fail_run();
    endtask

    task automatic expect_equal(input string sig, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp)
        else report_mismatch(sig, exp, act);
    endtask

    `include "booth_apb_tasks.svh"

    // no wait states on this slave
    pready_high: assert property (@(posedge clk) disable iff (!rst) rsp.pready)
        else report_mismatch("rsp.pready", 32'd1, 32'(rsp.pready));

    // an error response only ever comes in an access phase
    pslverr_in_access: assert property (@(posedge clk) disable iff (!rst)
        !rsp.pslverr || (req.psel && req.penable))
        else report_mismatch("rsp.pslverr", 32'd0, 32'(rsp.pslverr));

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d clock periods", WATCHDOG_CYCLES);
        fail_run();
    end

    initial begin
        logic        [31:0]      data;
        logic        [31:0]      rnd;
        logic                    err;
        logic signed [WIDTH-1:0] a;
        logic signed [WIDTH-1:0] b;

        clk  = 1'b0;
        rst  = 1'b0;
        req  = '0;
        seed = 32'hfa84;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        // state right after reset
        read_reg(ADDR_STATUS, data, err);
        expect_equal("STATUS", 32'h0, data);
        expect_equal("pslverr", 32'd0, 32'(err));
        read_reg(ADDR_RESULT, data, err);
        expect_equal("RESULT", 32'h0, data);
        expect_equal("pslverr", 32'd0, 32'(err));
        read_reg(ADDR_MCAND, data, err);
        expect_equal("MCAND", 32'h0, data);
        read_reg(ADDR_MPLIER, data, err);
        expect_equal("MPLIER", 32'h0, data);

        run_multiply(16'sd0, 16'sd12345);
        run_multiply(16'sd1, -16'sd1);
        run_multiply(16'sh8000, 16'sh8000);   // most negative squared
        run_multiply(16'sh7fff, 16'sh8000);
        run_multiply(16'sd3, 16'sd5);
        run_multiply(-16'sd7, 16'sd6);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd = $random(seed);
            a   = rnd[WIDTH-1:0];
            rnd = $random(seed);
            b   = rnd[WIDTH-1:0];
            run_multiply(a, b);
        end

        // operand and start writes are refused during a run
        a = -16'sd1234;
        b = 16'sd4321;
        start_multiply(a, b);
        write_reg(ADDR_MCAND, 32'h0000_1111, err);
        expect_equal("pslverr", 32'd1, 32'(err));
        write_reg(ADDR_MPLIER, 32'h0000_2222, err);
        expect_equal("pslverr", 32'd1, 32'(err));
        write_reg(ADDR_CTRL, 32'h1, err);
        expect_equal("pslverr", 32'd1, 32'(err));
        wait_for_done();
        check_result(a, b);
        read_reg(ADDR_MCAND, data, err);
        expect_equal("MCAND", to_word(a), data);
        read_reg(ADDR_MPLIER, data, err);
        expect_equal("MPLIER", to_word(b), data);

        // decode
        read_reg(ADDR_UNMAPPED, data, err);
        expect_equal("pslverr", 32'd1, 32'(err));
        write_reg(ADDR_UNMAPPED, 32'hdead_beef, err);
        expect_equal("pslverr", 32'd1, 32'(err));
        read_reg(ADDR_CTRL, data, err);
        expect_equal("CTRL", 32'h0, data);
        expect_equal("pslverr", 32'd0, 32'(err));

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: rtl/booth_mult_top.sv
module booth_mult_top (
    input  logic                clk,
    input  logic                rst,
    input  booth_pkg::apb_req_t req,
    output booth_pkg::apb_rsp_t rsp
);
    import booth_pkg::*;

    logic                      start;
    logic                      ready;
    logic                      count_comp;
    logic        [1:0]         q_pair;
    booth_ctl_t                ctl;
    logic        [WIDTH-1:0]   mcand;
    logic        [WIDTH-1:0]   mplier;
    logic signed [2*WIDTH-1:0] product;

    booth_apb_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .rsp     (rsp),
        .ready   (ready),
        .product (product),
        .start   (start),
        .mcand   (mcand),
        .mplier  (mplier)
    );

    booth_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .count_comp (count_comp),
        .q_pair     (q_pair),
        .ctl        (ctl),
        .ready      (ready)
    );

    booth_datapath u_dp (
        .clk     (clk),
        .rst     (rst),
        .ctl     (ctl),
        .mcand   (mcand),
        .mplier  (mplier),
        .q_pair  (q_pair),
        .product (product)
    );

    booth_counter u_cnt (
        .clk        (clk),
        .rst        (rst),
        .ctl        (ctl),
        .count_comp (count_comp)
    );

endmodule

// File: rtl/booth_counter.sv
module booth_counter (
    input  logic                  clk,
    input  logic                  rst,
    input  booth_pkg::booth_ctl_t ctl,
    output logic                  count_comp
);
    import booth_pkg::*;

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt <= '0;
        end else if (ctl.clear || ctl.load) begin
            cnt <= '0;
        end else if (ctl.step) begin
            cnt <= cnt + 1'b1;
        end
    end

    // high during the last Booth step
    assign count_comp = (cnt == CNT_W'(WIDTH - 1));

endmodule

// File: rtl/booth_datapath.sv
module booth_datapath (
    input  logic                                 clk,
    input  logic                                 rst,
    input  booth_pkg::booth_ctl_t                ctl,
    input  logic        [booth_pkg::WIDTH-1:0]   mcand,
    input  logic        [booth_pkg::WIDTH-1:0]   mplier,
    output logic        [1:0]                    q_pair,
    output logic signed [2*booth_pkg::WIDTH-1:0] product
);
    import booth_pkg::*;

    // A carries one guard bit, otherwise subtracting -2^(W-1) overflows
    logic signed [WIDTH:0]   acc;
    logic signed [WIDTH:0]   m_ext;   // multiplicand copy, sign extended
    logic        [WIDTH-1:0] q;
    logic                    q_m1;
    logic signed [WIDTH:0]   sum;

    always_comb begin
        case (ctl.op)
            OP_ADD:  sum = acc + m_ext;
            OP_SUB:  sum = acc - m_ext;
            default: sum = acc;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            acc   <= '0;
            m_ext <= '0;
            q     <= '0;
            q_m1  <= 1'b0;
        end else if (ctl.clear) begin
            acc  <= '0;
            q    <= '0;
            q_m1 <= 1'b0;
        end else if (ctl.load) begin
            acc   <= '0;
            m_ext <= {mcand[WIDTH-1], mcand};
            q     <= mplier;
            q_m1  <= 1'b0;
        end else if (ctl.step) begin
            // arithmetic right shift of {A, Q, Q-1}
            acc  <= {sum[WIDTH], sum[WIDTH:1]};
            q    <= {sum[0], q[WIDTH-1:1]};
            q_m1 <= q[0];
        end
    end

    assign q_pair = {q[0], q_m1};

    // guard bit dropped, product always fits in 2*WIDTH
    assign product = {acc[WIDTH-1:0], q};

endmodule

// File: rtl/booth_ctrl.sv
module booth_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  count_comp,
    input  logic [1:0]            q_pair,
    output booth_pkg::booth_ctl_t ctl,
    output logic                  ready
);
    import booth_pkg::*;

    typedef enum logic {
        IDLE,
        RUN
    } state_t;

    state_t state;
    state_t state_n;
    logic   last_step;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
            ready <= 1'b0;
        end else begin
            state <= state_n;
            ready <= last_step;   // a cycle late so the product has settled
        end
    end

    always_comb begin
        ctl       = '0;
        ctl.op    = OP_NONE;
        state_n   = state;
        last_step = 1'b0;
        case (state)
            IDLE: begin
                if (start) begin
                    ctl.load = 1'b1;
                    state_n  = RUN;
                end else begin
                    ctl.clear = 1'b1;
                end
            end
            RUN: begin
                ctl.step = 1'b1;
                case (q_pair)
                    2'b01:   ctl.op = OP_ADD;
                    2'b10:   ctl.op = OP_SUB;
                    2'b11:   ctl.op = OP_NONE2;
                    default: ctl.op = OP_NONE;
                endcase
                if (count_comp) begin
                    last_step = 1'b1;
                    state_n   = IDLE;
                end
            end
            default: state_n = IDLE;
        endcase
    end

endmodule

// File: rtl/booth_apb_regs.sv
module booth_apb_regs (
    input  logic                                 clk,
    input  logic                                 rst,
    input  booth_pkg::apb_req_t                  req,
    output booth_pkg::apb_rsp_t                  rsp,
    input  logic                                 ready,
    input  logic signed [2*booth_pkg::WIDTH-1:0] product,
    output logic                                 start,
    output logic        [booth_pkg::WIDTH-1:0]   mcand,
    output logic        [booth_pkg::WIDTH-1:0]   mplier
);
    import booth_pkg::*;

    logic        access;
    logic        mapped;
    logic        locked;     // operand/ctrl write attempted during a run
    logic        wr_ok;
    logic        start_req;
    logic        busy;
    logic        done;
    logic [31:0] result;

    assign access = req.psel & req.penable;

    always_comb begin
        case (req.paddr)
            ADDR_MCAND, ADDR_MPLIER, ADDR_CTRL, ADDR_STATUS, ADDR_RESULT: mapped = 1'b1;
            default: mapped = 1'b0;
        endcase
    end

    always_comb begin
        case (req.paddr)
            ADDR_MCAND, ADDR_MPLIER, ADDR_CTRL: locked = busy & req.pwrite;
            default: locked = 1'b0;
        endcase
    end

    assign wr_ok     = access & req.pwrite & mapped & !locked;
    assign start_req = wr_ok & (req.paddr == ADDR_CTRL) & req.pwdata[0];

    // response is combinational, no wait states
    always_comb begin
        rsp         = '0;
        rsp.pready  = 1'b1;
        rsp.pslverr = access & (!mapped | locked);
        case (req.paddr)
            ADDR_MCAND:  rsp.prdata = 32'(mcand);
            ADDR_MPLIER: rsp.prdata = 32'(mplier);
            ADDR_STATUS: rsp.prdata = {30'd0, done, busy};
            ADDR_RESULT: rsp.prdata = result;
            default:     rsp.prdata = '0;   // ctrl is write-only
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mcand  <= '0;
            mplier <= '0;
        end else if (wr_ok) begin
            if (req.paddr == ADDR_MCAND) begin
                mcand <= req.pwdata[WIDTH-1:0];
            end
            if (req.paddr == ADDR_MPLIER) begin
                mplier <= req.pwdata[WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            start  <= 1'b0;
            busy   <= 1'b0;
            done   <= 1'b0;
            result <= '0;
        end else begin
            start <= start_req;   // one cycle pulse
            if (start_req) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (ready) begin
                busy   <= 1'b0;
                done   <= 1'b1;   // sticky until next start
                result <= 32'(product);
            end
        end
    end

endmodule

// File: rtl/booth_pkg.sv
package booth_pkg;

    localparam int WIDTH  = 16;
    localparam int CNT_W  = $clog2(WIDTH);   // counts 0 .. WIDTH-1
    localparam int ADDR_W = 8;

    // register map
    localparam logic [ADDR_W-1:0] ADDR_MCAND  = 8'h00;
    localparam logic [ADDR_W-1:0] ADDR_MPLIER = 8'h04;
    localparam logic [ADDR_W-1:0] ADDR_CTRL   = 8'h08;   // bit 0 start, reads as zero
    localparam logic [ADDR_W-1:0] ADDR_STATUS = 8'h0C;   // bit 0 busy, bit 1 done
    localparam logic [ADDR_W-1:0] ADDR_RESULT = 8'h10;

    typedef struct packed {
        logic [ADDR_W-1:0] paddr;
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [31:0]       pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // encoding follows the Q0/Q-1 bit pair directly
    typedef enum logic [1:0] {
        OP_NONE  = 2'b00,
        OP_ADD   = 2'b01,
        OP_SUB   = 2'b10,
        OP_NONE2 = 2'b11
    } booth_op_e;

    typedef struct packed {
        logic      clear;
        logic      load;
        logic      step;
        booth_op_e op;
    } booth_ctl_t;

endpackage
